// ==== compile.f ====
+incdir+include
verilog/ddr4_traffic_pkg.sv
verilog/traffic_apb_regs.sv
verilog/traffic_fsm.sv
verilog/traffic_counter.sv
verilog/traffic_datapath.sv
verilog/ddr4_traffic_top.sv
verification/ddr4_traffic_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the DDR4 traffic checker testbench with Verilator
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -f compile.f \
  --top-module ddr4_traffic_tb -o sim_ddr4_traffic \
  && ./obj_dir/sim_ddr4_traffic > sim.log 2>&1 \
  || { echo "build or simulation failed"; cat sim.log 2>/dev/null; exit 1; }

cat sim.log
grep -qx ">>> PASS" sim.log && echo "simulation passed" && exit 0 \
  || { echo "simulation failed"; exit 1; }

// ==== verification/ddr4_traffic_tb.sv ====
`include "ddr4_traffic_cfg.svh"

module ddr4_traffic_tb
  import ddr4_traffic_pkg::*;
();

  localparam integer CLK_PERIOD      = 20;
  localparam integer TOTAL_BEATS     = 24 + 64 + 32 + 20;
  localparam integer MAX_STALL       = 8;
  localparam integer DROP_LIMIT      = 50;
  localparam integer WATCHDOG_CYCLES = 2 * TOTAL_BEATS * MAX_STALL + DROP_LIMIT + 2000;

  logic        c0_ddr4_clk;
  logic        rst_n_i;
  logic        psel_i;
  logic        penable_i;
  logic        pwrite_i;
  logic [7:0]  paddr_i;
  logic [31:0] pwdata_i;
  logic [31:0] prdata_o;
  logic        pready_o;
  logic        pslverr_o;
  logic        init_calib_complete_i;
  logic        app_rdy_i;
  logic        app_wdf_rdy_i;
  ddr_data_t   app_rd_data_i;
  logic        app_rd_data_valid_i;
  logic        app_en_o;
  app_cmd_t    app_cmd_o;
  ddr_addr_t   app_addr_o;
  ddr_data_t   app_wdf_data_o;
  logic        app_wdf_wren_o;
  logic        app_wdf_end_o;
  logic        test_done_o;
  logic        data_compare_error_o;

  integer      seed;
  integer      errors;
  integer      checks;
  // Controller and memory model state
  integer      wr_seen;
  integer      rd_seen;
  integer      ret_seen;
  logic        stall_en;
  logic        drop_last;
  ddr_addr_t   cfg_base;
  integer      cfg_count;
  logic [31:0] cfg_seed;
  ddr_data_t   mem [ddr_addr_t];
  ddr_data_t   pending_q [$];
  integer      corrupt_bit [integer];

  ddr4_traffic_top uut (.*);

  initial begin
    c0_ddr4_clk = 1'b0;
    forever #(CLK_PERIOD / 2) c0_ddr4_clk = ~c0_ddr4_clk;
  end

  // ********************
  // Checks and pattern model
  // ********************
  task automatic check_value(input string name, input logic [63:0] expected,
                             input logic [63:0] actual);
    checks = checks + 1;
    if (actual !== expected) begin
      errors = errors + 1;
      $display("FAILED at %0t: %s expected %h, got %h", $time, name, expected, actual);
    end
  endtask

  task automatic report_failure(input string msg);
    errors = errors + 1;
    $display("ERROR at %0t: %s", $time, msg);
  endtask

  task automatic finish_test(input string name, input integer err_start);
    if (errors == err_start) $display("test %s: passed", name);
    else $display("test %s: failed with %0d errors", name, errors - err_start);
  endtask

  // Beat i sits at base + 8i, upper half seed + i, lower half inverted
  function automatic ddr_addr_t beat_addr(input integer i);
    beat_addr = ddr_addr_t'(32'(cfg_base) + 32'(i) * 8);
  endfunction

  function automatic ddr_data_t beat_data(input integer i);
    logic [31:0] hi;
    hi = cfg_seed + 32'(i);
    beat_data = {hi, ~hi};
  endfunction

  // Transfers are decided by values stable since the last rising edge
  always @(negedge c0_ddr4_clk) begin
    ddr_data_t word;
    if (rst_n_i && app_en_o && app_rdy_i) begin
      if (app_cmd_o == CMD_WRITE && app_wdf_rdy_i) begin
        check_value("app_addr_o (write)", 64'(beat_addr(wr_seen)), 64'(app_addr_o));
        check_value("app_wdf_data_o", beat_data(wr_seen), app_wdf_data_o);
        check_value("app_wdf_wren_o", 1, app_wdf_wren_o);
        check_value("app_wdf_end_o", 1, app_wdf_end_o);
        mem[app_addr_o] = app_wdf_data_o;
        wr_seen = wr_seen + 1;
      end else if (app_cmd_o == CMD_READ) begin
        check_value("app_addr_o (read)", 64'(beat_addr(rd_seen)), 64'(app_addr_o));
        check_value("writes before read", cfg_count, wr_seen);
        check_value("app_wdf_wren_o (read)", 0, app_wdf_wren_o);
        check_value("app_wdf_end_o (read)", 0, app_wdf_end_o);
        word = mem.exists(app_addr_o) ? mem[app_addr_o] : '0;
        if (corrupt_bit.exists(rd_seen)) word = word ^ (64'd1 << corrupt_bit[rd_seen]);
        if (!(drop_last && rd_seen == cfg_count - 1)) pending_q.push_back(word);
        rd_seen = rd_seen + 1;
      end else if (app_cmd_o != CMD_WRITE) begin
        report_failure("controller model saw an unknown command code");
      end
    end
  end

  // Ready toggling and in-order read returns with random delay
  always @(posedge c0_ddr4_clk) begin
    #1;
    app_rdy_i     = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    app_wdf_rdy_i = stall_en ? (($random(seed) & 3) != 0) : 1'b1;
    if (pending_q.size() > 0 && ($random(seed) & 3) != 0) begin
      app_rd_data_i       = pending_q.pop_front();
      app_rd_data_valid_i = 1'b1;
      ret_seen            = ret_seen + 1;
    end else begin
      app_rd_data_i       = '0;
      app_rd_data_valid_i = 1'b0;
    end
  end

  // ********************
  // APB driver
  // ********************
  task automatic apb_access(input logic write, input logic [7:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic slverr);
    @(posedge c0_ddr4_clk);
    #1;
    psel_i    = 1'b1;
    penable_i = 1'b0;
    pwrite_i  = write;
    paddr_i   = addr;
    pwdata_i  = wdata;
    @(posedge c0_ddr4_clk);
    #1;
    penable_i = 1'b1;
    // Zero wait states, so the first access cycle completes the transfer
    @(negedge c0_ddr4_clk);
    check_value("pready_o", 1, pready_o);
    rdata  = prdata_o;
    slverr = pslverr_o;
    @(posedge c0_ddr4_clk);
    #1;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
  endtask

  task automatic apb_write(input logic [7:0] addr, input logic [31:0] wdata);
    logic [31:0] rdata;
    logic        slverr;
    apb_access(1'b1, addr, wdata, rdata, slverr);
  endtask

  task automatic apb_read(input logic [7:0] addr, output logic [31:0] rdata);
    logic slverr;
    apb_access(1'b0, addr, 32'd0, rdata, slverr);
  endtask

  task automatic reg_roundtrip(input string name, input logic [7:0] addr,
                               input logic [31:0] mask);
    logic [31:0] value;
    logic [31:0] rdata;
    logic        slverr;
    value = $random(seed) & mask;
    apb_write(addr, value);
    apb_access(1'b0, addr, 32'd0, rdata, slverr);
    check_value(name, value, rdata);
    check_value("pslverr_o", 0, slverr);
  endtask

  // ********************
  // Run control
  // ********************
  task automatic run_traffic(input integer count, input integer limit, input logic stall,
                             input logic drop, input integer corrupt_k);
    integer idx;
    cfg_base  = ddr_addr_t'($random(seed) & 32'hFFFF_FFF8);
    cfg_count = count;
    cfg_seed  = $random(seed);
    stall_en  = stall;
    drop_last = drop;
    wr_seen   = 0;
    rd_seen   = 0;
    ret_seen  = 0;
    mem.delete();
    corrupt_bit.delete();
    while (corrupt_bit.num() < corrupt_k) begin
      idx = {$random(seed)} % count;
      if (!corrupt_bit.exists(idx)) corrupt_bit[idx] = {$random(seed)} % 64;
    end
    apb_write(`REG_BASE, 32'(cfg_base));
    apb_write(`REG_COUNT, count);
    apb_write(`REG_SEED, cfg_seed);
    apb_write(`REG_TIMEOUT, limit);
    apb_write(`REG_CTRL, 32'd1);
  endtask

  task automatic wait_done(input integer max_cycles);
    integer n;
    n = 0;
    while (!test_done_o && n < max_cycles) begin
      @(negedge c0_ddr4_clk);
      n = n + 1;
    end
    if (!test_done_o) report_failure($sformatf("run not done within %0d cycles", max_cycles));
  endtask

  task automatic check_run_end(input integer exp_err, input logic [3:0] exp_status,
                               input integer exp_returns);
    logic [31:0] rdata;
    apb_read(`REG_ERRCNT, rdata);
    check_value("ERRCNT", exp_err, rdata);
    apb_read(`REG_STATUS, rdata);
    check_value("STATUS", exp_status, rdata & 32'hF);
    check_value("data_compare_error_o", exp_err != 0, data_compare_error_o);
    check_value("test_done_o", 1, test_done_o);
    check_value("app_en_o", 0, app_en_o);
    check_value("writes seen", cfg_count, wr_seen);
    check_value("reads seen", cfg_count, rd_seen);
    check_value("returns sent", exp_returns, ret_seen);
    check_value("returns pending", 0, pending_q.size());
  endtask

  // ********************
  // Tests
  // ********************
  task automatic test_register_access;
    integer      err_start;
    logic [31:0] rdata;
    logic        slverr;
    err_start = errors;
    @(negedge c0_ddr4_clk);
    check_value("app_en_o", 0, app_en_o);
    check_value("app_wdf_wren_o", 0, app_wdf_wren_o);
    check_value("app_wdf_end_o", 0, app_wdf_end_o);
    check_value("test_done_o", 0, test_done_o);
    check_value("data_compare_error_o", 0, data_compare_error_o);
    check_value("pslverr_o", 0, pslverr_o);
    reg_roundtrip("BASE", `REG_BASE, 32'h0FFF_FFFF);
    reg_roundtrip("COUNT", `REG_COUNT, 32'h0000_FFFF);
    reg_roundtrip("SEED", `REG_SEED, 32'hFFFF_FFFF);
    reg_roundtrip("TIMEOUT", `REG_TIMEOUT, 32'h0000_FFFF);
    apb_access(1'b0, 8'h20, 32'd0, rdata, slverr);
    check_value("pslverr_o (unmapped read)", 1, slverr);
    apb_access(1'b1, 8'h3C, 32'd5, rdata, slverr);
    check_value("pslverr_o (unmapped write)", 1, slverr);
    finish_test("register_access", err_start);
  endtask

  task automatic test_clean_run;
    integer err_start;
    err_start = errors;
    init_calib_complete_i = 1'b0;
    run_traffic(24, 200, 1'b0, 1'b0, 0);
    repeat (6) @(negedge c0_ddr4_clk);
    check_value("app_en_o before calibration", 0, app_en_o);
    check_value("writes before calibration", 0, wr_seen);
    @(posedge c0_ddr4_clk);
    #1;
    init_calib_complete_i = 1'b1;
    wait_done(24 * 2 * MAX_STALL + 200 + 100);
    check_run_end(0, 4'b0010, 24);
    finish_test("clean_run", err_start);
  endtask

  task automatic test_back_pressure;
    integer err_start;
    err_start = errors;
    run_traffic(64, 200, 1'b1, 1'b0, 0);
    wait_done(64 * 2 * MAX_STALL + 200 + 100);
    check_run_end(0, 4'b0010, 64);
    stall_en = 1'b0;
    finish_test("back_pressure", err_start);
  endtask

  task automatic test_corruption;
    integer err_start;
    err_start = errors;
    run_traffic(32, 200, 1'b0, 1'b0, 3);
    wait_done(32 * 2 * MAX_STALL + 200 + 100);
    check_run_end(3, 4'b0110, 32);
    finish_test("corruption", err_start);
  endtask

  task automatic test_timeout;
    integer      err_start;
    integer      n;
    logic [31:0] rdata;
    err_start = errors;
    run_traffic(20, DROP_LIMIT, 1'b0, 1'b1, 0);
    n = 0;
    while (wr_seen < 5 && n < 200) begin
      @(negedge c0_ddr4_clk);
      n = n + 1;
    end
    // Restart attempt in the middle of the run
    apb_write(`REG_CTRL, 32'd1);
    apb_read(`REG_STATUS, rdata);
    check_value("STATUS busy", 1, rdata[0]);
    wait_done(20 * 2 * MAX_STALL + DROP_LIMIT + 100);
    check_run_end(0, 4'b1010, 19);
    finish_test("timeout", err_start);
  endtask

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the run hung", WATCHDOG_CYCLES);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    seed                  = 86662;
    errors                = 0;
    checks                = 0;
    wr_seen               = 0;
    rd_seen               = 0;
    ret_seen              = 0;
    stall_en              = 1'b0;
    drop_last             = 1'b0;
    cfg_base              = '0;
    cfg_count             = 0;
    cfg_seed              = '0;
    rst_n_i               = 1'b0;
    psel_i                = 1'b0;
    penable_i             = 1'b0;
    pwrite_i              = 1'b0;
    paddr_i               = '0;
    pwdata_i              = '0;
    init_calib_complete_i = 1'b0;
    app_rdy_i             = 1'b0;
    app_wdf_rdy_i         = 1'b0;
    app_rd_data_i         = '0;
    app_rd_data_valid_i   = 1'b0;
    repeat (8) @(posedge c0_ddr4_clk);
    #1;
    rst_n_i = 1'b1;
    test_register_access();
    test_clean_run();
    test_back_pressure();
    test_corruption();
    test_timeout();
    $display("tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display(">>> PASS");
    end else begin
      $display(">>> FAIL");
    end
    $finish;
  end

endmodule

// ==== verilog/ddr4_traffic_top.sv ====
module ddr4_traffic_top
  import ddr4_traffic_pkg::*;
(
  input  logic        c0_ddr4_clk,
  input  logic        rst_n_i,
  // APB slave
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  // Memory controller application interface
  input  logic        init_calib_complete_i,
  input  logic        app_rdy_i,
  input  logic        app_wdf_rdy_i,
  input  ddr_data_t   app_rd_data_i,
  input  logic        app_rd_data_valid_i,
  output logic        app_en_o,
  output app_cmd_t    app_cmd_o,
  output ddr_addr_t   app_addr_o,
  output ddr_data_t   app_wdf_data_o,
  output logic        app_wdf_wren_o,
  output logic        app_wdf_end_o,
  // Run status
  output logic        test_done_o,
  output logic        data_compare_error_o
);

  logic        start;
  ddr_addr_t   base;
  beat_cnt_t   count;
  logic [31:0] seed;
  timeout_t    timeout_cfg;
  logic        busy;
  logic        timed_out;
  beat_cnt_t   err_cnt;
  logic        issue;
  logic        clear;
  logic        last_issue;
  logic        last_return;
  logic        wd_timeout;
  beat_cnt_t   issue_idx;
  beat_cnt_t   return_idx;

  // Single-beat writes, so every data word ends its burst
  assign app_wdf_end_o        = app_wdf_wren_o;
  assign data_compare_error_o = |err_cnt;

  traffic_apb_regs u_regs (
    .c0_ddr4_clk (c0_ddr4_clk),
    .rst_n_i     (rst_n_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .paddr_i     (paddr_i),
    .pwdata_i    (pwdata_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .start_o     (start),
    .base_o      (base),
    .count_o     (count),
    .seed_o      (seed),
    .timeout_o   (timeout_cfg),
    .busy_i      (busy),
    .done_i      (test_done_o),
    .timed_out_i (timed_out),
    .err_cnt_i   (err_cnt)
  );

  traffic_fsm u_fsm (
    .c0_ddr4_clk           (c0_ddr4_clk),
    .rst_n_i               (rst_n_i),
    .start_i               (start),
    .init_calib_complete_i (init_calib_complete_i),
    .app_rdy_i             (app_rdy_i),
    .app_wdf_rdy_i         (app_wdf_rdy_i),
    .last_issue_i          (last_issue),
    .last_return_i         (last_return),
    .timeout_i             (wd_timeout),
    .count_i               (count),
    .state_o               (),
    .issue_o               (issue),
    .clear_o               (clear),
    .app_en_o              (app_en_o),
    .app_wdf_wren_o        (app_wdf_wren_o),
    .busy_o                (busy),
    .done_o                (test_done_o),
    .timed_out_o           (timed_out),
    .app_cmd_o             (app_cmd_o)
  );

  traffic_counter u_counter (
    .c0_ddr4_clk   (c0_ddr4_clk),
    .rst_n_i       (rst_n_i),
    .clear_i       (clear),
    .issue_i       (issue),
    .return_i      (app_rd_data_valid_i),
    .count_i       (count),
    .timeout_i     (timeout_cfg),
    .issue_idx_o   (issue_idx),
    .return_idx_o  (return_idx),
    .last_issue_o  (last_issue),
    .last_return_o (last_return),
    .timeout_o     (wd_timeout)
  );

  traffic_datapath u_datapath (
    .c0_ddr4_clk    (c0_ddr4_clk),
    .rst_n_i        (rst_n_i),
    .clear_i        (clear),
    .rd_valid_i     (app_rd_data_valid_i),
    .base_i         (base),
    .seed_i         (seed),
    .issue_idx_i    (issue_idx),
    .return_idx_i   (return_idx),
    .rd_data_i      (app_rd_data_i),
    .app_addr_o     (app_addr_o),
    .app_wdf_data_o (app_wdf_data_o),
    .err_cnt_o      (err_cnt)
  );

endmodule

// ==== verilog/traffic_datapath.sv ====
module traffic_datapath
  import ddr4_traffic_pkg::*;
(
  input  logic        c0_ddr4_clk,
  input  logic        rst_n_i,
  input  logic        clear_i,
  input  logic        rd_valid_i,
  input  ddr_addr_t   base_i,
  input  logic [31:0] seed_i,
  input  beat_cnt_t   issue_idx_i,
  input  beat_cnt_t   return_idx_i,
  input  ddr_data_t   rd_data_i,
  output ddr_addr_t   app_addr_o,
  output ddr_data_t   app_wdf_data_o,
  output beat_cnt_t   err_cnt_o
);

  logic [31:0] wr_hi;
  logic [31:0] exp_hi;
  ddr_data_t   exp_data;
  logic        mismatch;

  // ********************
  // Pattern generation
  // ********************

  // One 64-bit word per beat, so 8 bytes between beats
  assign app_addr_o = base_i + ddr_addr_t'({issue_idx_i, 3'b000});

  // Upper half counts from the seed, lower half is its inverse
  assign wr_hi          = seed_i + 32'(issue_idx_i);
  assign app_wdf_data_o = {wr_hi, ~wr_hi};

  // Expected word for the read now returning
  assign exp_hi   = seed_i + 32'(return_idx_i);
  assign exp_data = {exp_hi, ~exp_hi};
  assign mismatch = rd_valid_i && (rd_data_i != exp_data);

  // ********************
  // Compare and count
  // ********************
  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      err_cnt_o <= '0;
    end else if (clear_i) begin
      err_cnt_o <= '0;
    end else if (mismatch && err_cnt_o != '1) begin
      // saturate rather than wrap back to zero
      err_cnt_o <= err_cnt_o + 1'b1;
    end
  end

endmodule

// ==== verilog/traffic_counter.sv ====
module traffic_counter
  import ddr4_traffic_pkg::*;
(
  input  logic      c0_ddr4_clk,
  input  logic      rst_n_i,
  input  logic      clear_i,
  input  logic      issue_i,
  input  logic      return_i,
  input  beat_cnt_t count_i,
  input  timeout_t  timeout_i,
  output beat_cnt_t issue_idx_o,
  output beat_cnt_t return_idx_o,
  output logic      last_issue_o,
  output logic      last_return_o,
  output logic      timeout_o
);

  beat_cnt_t last_idx;
  timeout_t  idle_cnt_q;
  logic      outstanding;

  assign last_idx    = count_i - 1'b1;
  assign outstanding = (issue_idx_o != return_idx_o);

  // Final beat flags, qualified by the transfer itself
  assign last_issue_o  = issue_i && (issue_idx_o == last_idx);
  assign last_return_o = return_i && (return_idx_o == last_idx);

  assign timeout_o = outstanding && (idle_cnt_q >= timeout_i);

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      issue_idx_o  <= '0;
      return_idx_o <= '0;
      idle_cnt_q   <= '0;
    end else if (clear_i) begin
      issue_idx_o  <= '0;
      return_idx_o <= '0;
      idle_cnt_q   <= '0;
    end else begin
      if (issue_i) issue_idx_o <= issue_idx_o + 1'b1;
      if (return_i) return_idx_o <= return_idx_o + 1'b1;
      // Watchdog restarts on every return, holds at its ceiling
      if (return_i || !outstanding) begin
        idle_cnt_q <= '0;
      end else if (idle_cnt_q != '1) begin
        idle_cnt_q <= idle_cnt_q + 1'b1;
      end
    end
  end

  // Controller must never return more reads than were issued
  a_no_extra_return: assert property (
    @(posedge c0_ddr4_clk) disable iff (!rst_n_i) return_idx_o <= issue_idx_o);

endmodule

// ==== verilog/traffic_fsm.sv ====
module traffic_fsm
  import ddr4_traffic_pkg::*;
(
  input  logic           c0_ddr4_clk,
  input  logic           rst_n_i,
  input  logic           start_i,
  input  logic           init_calib_complete_i,
  input  logic           app_rdy_i,
  input  logic           app_wdf_rdy_i,
  input  logic           last_issue_i,
  input  logic           last_return_i,
  input  logic           timeout_i,
  input  beat_cnt_t      count_i,
  output traffic_state_t state_o,
  output logic           issue_o,
  output logic           clear_o,
  output logic           app_en_o,
  output logic           app_wdf_wren_o,
  output logic           busy_o,
  output logic           done_o,
  output logic           timed_out_o,
  output app_cmd_t       app_cmd_o
);

  traffic_state_t state_q;
  traffic_state_t state_d;
  logic           rd_issued_q;
  logic           start_ok;
  logic           rd_timeout;

  // Start only counts outside a run
  assign start_ok   = start_i && (state_q == ST_IDLE || state_q == ST_DONE);
  assign rd_timeout = (state_q == ST_READ) && timeout_i && rd_issued_q && !last_return_i;

  // Command stays up until the controller takes it
  assign app_en_o       = (state_q == ST_WRITE) || (state_q == ST_READ && !rd_issued_q);
  assign app_wdf_wren_o = (state_q == ST_WRITE);
  assign app_cmd_o      = (state_q == ST_READ) ? CMD_READ : CMD_WRITE;
  assign issue_o        = app_en_o && app_rdy_i && (app_wdf_rdy_i || !app_wdf_wren_o);

  // Restart indices at a new run and again before the read phase
  assign clear_o = start_ok || (state_q == ST_WRITE && last_issue_i);

  assign state_o = state_q;
  assign busy_o  = (state_q == ST_CALIB) || (state_q == ST_WRITE) || (state_q == ST_READ);
  assign done_o  = (state_q == ST_DONE);

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_DONE: if (start_ok) state_d = ST_CALIB;
      ST_CALIB: begin
        if (init_calib_complete_i) begin
          state_d = (count_i == '0) ? ST_DONE : ST_WRITE;
        end
      end
      ST_WRITE: if (last_issue_i) state_d = ST_READ;
      ST_READ:  if (last_return_i || rd_timeout) state_d = ST_DONE;
      default:  state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      state_q     <= ST_IDLE;
      rd_issued_q <= 1'b0;
      timed_out_o <= 1'b0;
    end else begin
      state_q <= state_d;
      if (clear_o) begin
        rd_issued_q <= 1'b0;
      end else if (state_q == ST_READ && last_issue_i) begin
        rd_issued_q <= 1'b1;
      end
      if (start_ok) begin
        timed_out_o <= 1'b0;
      end else if (rd_timeout) begin
        timed_out_o <= 1'b1;
      end
    end
  end

  // A raised command is never withdrawn before it transfers
  property p_en_held;
    @(posedge c0_ddr4_clk) disable iff (!rst_n_i)
      app_en_o && !issue_o |=> app_en_o && $stable(app_cmd_o);
  endproperty
  a_en_held: assert property (p_en_held);

endmodule

// ==== verilog/traffic_apb_regs.sv ====
`include "ddr4_traffic_cfg.svh"

module traffic_apb_regs
  import ddr4_traffic_pkg::*;
(
  input  logic        c0_ddr4_clk,
  input  logic        rst_n_i,
  input  logic        psel_i,
  input  logic        penable_i,
  input  logic        pwrite_i,
  input  logic [7:0]  paddr_i,
  input  logic [31:0] pwdata_i,
  output logic [31:0] prdata_o,
  output logic        pready_o,
  output logic        pslverr_o,
  output logic        start_o,
  output ddr_addr_t   base_o,
  output beat_cnt_t   count_o,
  output logic [31:0] seed_o,
  output timeout_t    timeout_o,
  input  logic        busy_i,
  input  logic        done_i,
  input  logic        timed_out_i,
  input  beat_cnt_t   err_cnt_i
);

  logic access;
  logic wr_en;
  logic mapped;

  // Access phase of any transfer
  assign access = psel_i && penable_i;
  assign wr_en  = access && pwrite_i;

  // No wait states
  assign pready_o  = access;
  assign pslverr_o = access && !mapped;

  // Start is a one-cycle strobe, nothing is stored
  assign start_o = wr_en && (paddr_i == `REG_CTRL) && pwdata_i[0];

  // ********************
  // Configuration registers
  // ********************
  always_ff @(posedge c0_ddr4_clk) begin
    if (!rst_n_i) begin
      base_o    <= '0;
      count_o   <= '0;
      seed_o    <= '0;
      timeout_o <= '1;
    end else if (wr_en) begin
      case (paddr_i)
        `REG_BASE:    base_o    <= pwdata_i[`DDR_ADDR_W-1:0];
        `REG_COUNT:   count_o   <= pwdata_i[`BEAT_CNT_W-1:0];
        `REG_SEED:    seed_o    <= pwdata_i;
        `REG_TIMEOUT: timeout_o <= pwdata_i[`TIMEOUT_W-1:0];
        default: ;
      endcase
    end
  end

  // Read-back mux, valid in the access phase
  always_comb begin
    prdata_o = '0;
    mapped   = 1'b1;
    case (paddr_i)
      `REG_CTRL:    prdata_o = '0;
      `REG_BASE:    prdata_o = 32'(base_o);
      `REG_COUNT:   prdata_o = 32'(count_o);
      `REG_SEED:    prdata_o = seed_o;
      `REG_STATUS:  prdata_o = {28'd0, timed_out_i, |err_cnt_i, done_i, busy_i};
      `REG_ERRCNT:  prdata_o = 32'(err_cnt_i);
      `REG_TIMEOUT: prdata_o = 32'(timeout_o);
      default:      mapped   = 1'b0;
    endcase
  end

  // APB master must hold psel while raising penable
  property p_enable_needs_sel;
    @(posedge c0_ddr4_clk) disable iff (!rst_n_i)
      $rose(penable_i) |-> psel_i;
  endproperty
  a_enable_needs_sel: assert property (p_enable_needs_sel);

endmodule

// ==== verilog/ddr4_traffic_pkg.sv ====
`include "ddr4_traffic_cfg.svh"

package ddr4_traffic_pkg;

  // Byte address on the application interface
  typedef logic [`DDR_ADDR_W-1:0] ddr_addr_t;

  // One full application data word
  typedef logic [`DDR_DATA_W-1:0] ddr_data_t;

  // Beat count and beat index
  typedef logic [`BEAT_CNT_W-1:0] beat_cnt_t;

  // Watchdog limit in cycles
  typedef logic [`TIMEOUT_W-1:0] timeout_t;

  // Application command codes
  typedef logic [2:0] app_cmd_t;
  localparam app_cmd_t CMD_WRITE = 3'd0;
  localparam app_cmd_t CMD_READ  = 3'd1;

  // Run sequencer states
  typedef enum logic [2:0] {
    ST_IDLE,
    ST_CALIB,
    ST_WRITE,
    ST_READ,
    ST_DONE
  } traffic_state_t;

endpackage

// ==== include/ddr4_traffic_cfg.svh ====
`ifndef DDR4_TRAFFIC_CFG_SVH
`define DDR4_TRAFFIC_CFG_SVH

// Application interface widths
`define DDR_ADDR_W 28
`define DDR_DATA_W 64

// Run sizing
`define BEAT_CNT_W 16
`define TIMEOUT_W  16

// ********************
// APB register offsets
// ********************
`define REG_CTRL    8'h00
`define REG_BASE    8'h04
`define REG_COUNT   8'h08
`define REG_SEED    8'h0C
`define REG_STATUS  8'h10
`define REG_ERRCNT  8'h14
`define REG_TIMEOUT 8'h18

`endif
